// File: hw/icache_macros.svh
`ifndef ICACHE_MACROS_SVH
`define ICACHE_MACROS_SVH

// address split into tag, index and byte offset
`define ICACHE_TAG_W     19
`define ICACHE_INDEX_W   8
`define ICACHE_OFFSET_W  5

`define ICACHE_WORDS     8     // 32-bit words per line
`define ICACHE_SETS      256

// rd_type encodings on the memory bus
`define RD_TYPE_WORD     2
`define RD_TYPE_LINE     7

`endif

// File: hw/icache_pkg.sv
`include "icache_macros.svh"

package icache_pkg;

    typedef struct packed {
        logic [`ICACHE_TAG_W-1:0]    tag;
        logic [`ICACHE_INDEX_W-1:0]  index;
        logic [`ICACHE_OFFSET_W-1:0] offset;
        logic                        uncached;  // bypass the arrays
    } cpu_req_t;

    typedef struct packed {
        logic [`ICACHE_TAG_W-1:0] tag;
        logic                     valid;
    } tag_entry_t;

    // word 0 sits in the low 32 bits
    typedef logic [`ICACHE_WORDS-1:0][31:0] line_t;

    typedef struct packed {
        cpu_req_t   req;
        logic [1:0] way_valid;  // valid bits seen in lookup
    } miss_req_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] data;
    } fill_resp_t;

    typedef struct packed {
        logic                       we0;
        logic                       we1;
        logic [`ICACHE_INDEX_W-1:0] index;
        tag_entry_t                 tag;
        line_t                      line;
    } array_wr_t;

endpackage

// File: hw/set_ram.sv
`timescale 1ns/1ps
`include "icache_macros.svh"

module set_ram #(
    parameter type entry_t = logic [31:0]
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic [`ICACHE_INDEX_W-1:0] rd_index,
    input  logic                       wr_en,
    input  logic [`ICACHE_INDEX_W-1:0] wr_index,
    input  entry_t                     wr_entry,
    output entry_t                     rd_entry
);

    entry_t mem [`ICACHE_SETS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `ICACHE_SETS; i++) begin
                mem[i] <= '0;  // all tags come up invalid
            end
            rd_entry <= '0;
        end else begin
            if (wr_en) begin
                mem[wr_index] <= wr_entry;
            end
            rd_entry <= mem[rd_index];  // old data on same-index write
        end
    end

endmodule

// File: hw/icache_lookup_stage.sv
`timescale 1ns/1ps
`include "icache_macros.svh"

module icache_lookup_stage (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       valid,
    input  icache_pkg::cpu_req_t       req,
    input  icache_pkg::tag_entry_t     tag0,
    input  icache_pkg::tag_entry_t     tag1,
    input  icache_pkg::line_t          line0,
    input  icache_pkg::line_t          line1,
    input  logic                       busy,
    input  icache_pkg::fill_resp_t     fill,
    output logic                       addr_ok,
    output logic                       data_ok,
    output logic [31:0]                rdata,
    output logic [`ICACHE_INDEX_W-1:0] rd_index,
    output logic                       miss_valid,
    output icache_pkg::miss_req_t      miss
);
    import icache_pkg::*;

    localparam int WORD_W = $clog2(`ICACHE_WORDS);

    cpu_req_t          req_q;
    logic              lookup_valid;
    logic              accept;
    logic              hit0;
    logic              hit1;
    logic              hit;
    logic [WORD_W-1:0] word_sel;
    logic [31:0]       hit_word;

    assign accept = valid && addr_ok;

    // array index follows the new request, else holds
    assign rd_index = accept ? req.index : req_q.index;

    assign word_sel = req_q.offset[`ICACHE_OFFSET_W-1:2];

    assign hit0 = tag0.valid && (tag0.tag == req_q.tag);
    assign hit1 = tag1.valid && (tag1.tag == req_q.tag);
    assign hit  = lookup_valid && !req_q.uncached && (hit0 || hit1);

    assign hit_word = hit1 ? line1[word_sel] : line0[word_sel];

    // uncached always goes to the bus
    assign miss_valid = lookup_valid && !hit;
    assign miss       = '{req: req_q, way_valid: {tag1.valid, tag0.valid}};

    // stalls from the miss cycle until refill drops busy
    assign addr_ok = !miss_valid && !busy;

    assign data_ok = hit || fill.valid;
    assign rdata   = fill.valid ? fill.data : hit_word;

    always_ff @(posedge clk) begin
        if (reset) begin
            lookup_valid <= 1'b0;
        end else begin
            lookup_valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= req;
        end
    end

endmodule

// File: hw/icache_refill_stage.sv
`timescale 1ns/1ps
`include "icache_macros.svh"

module icache_refill_stage (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   miss_valid,
    input  icache_pkg::miss_req_t  miss,
    input  logic                   rd_rdy,
    input  logic                   ret_valid,
    input  logic                   ret_last,
    input  logic [31:0]            ret_data,
    output logic                   busy,
    output icache_pkg::fill_resp_t fill,
    output logic                   rd_req,
    output logic [2:0]             rd_type,
    output logic [31:0]            rd_addr,
    output icache_pkg::array_wr_t  wr
);
    import icache_pkg::*;

    localparam int BEAT_W = $clog2(`ICACHE_WORDS);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,
        ST_RET
    } state_t;

    state_t                   state;
    miss_req_t                miss_q;
    logic                     victim_way;
    logic                     new_victim;
    logic [BEAT_W-1:0]        beat;
    line_t                    line_buf;
    line_t                    fill_line;
    logic [`ICACHE_SETS-1:0]  victim_bits;
    logic                     beat_ok;
    logic                     done;
    logic                     line_done;
    logic [BEAT_W-1:0]        word_sel;

    // invalid way first, then the per-set bit
    always_comb begin
        if (!miss.way_valid[0]) begin
            new_victim = 1'b0;
        end else if (!miss.way_valid[1]) begin
            new_victim = 1'b1;
        end else begin
            new_victim = victim_bits[miss.req.index];
        end
    end

    assign word_sel  = miss_q.req.offset[`ICACHE_OFFSET_W-1:2];
    assign beat_ok   = (state == ST_RET) && ret_valid;
    assign done      = beat_ok && (miss_q.req.uncached || ret_last);
    assign line_done = beat_ok && ret_last && !miss_q.req.uncached;

    assign busy   = (state != ST_IDLE);
    assign rd_req = (state == ST_REQ);

    assign rd_type = miss_q.req.uncached ? 3'(`RD_TYPE_WORD) : 3'(`RD_TYPE_LINE);
    assign rd_addr = miss_q.req.uncached ?
                     {miss_q.req.tag, miss_q.req.index, miss_q.req.offset} :
                     {miss_q.req.tag, miss_q.req.index, {`ICACHE_OFFSET_W{1'b0}}};

    // requested word goes straight back to the cpu
    assign fill.valid = beat_ok && (miss_q.req.uncached || (beat == word_sel));
    assign fill.data  = ret_data;

    // last beat merged in so the line is written in one go
    always_comb begin
        fill_line       = line_buf;
        fill_line[beat] = ret_data;
    end

    assign wr.we0   = line_done && !victim_way;
    assign wr.we1   = line_done && victim_way;
    assign wr.index = miss_q.req.index;
    assign wr.tag   = '{tag: miss_q.req.tag, valid: 1'b1};
    assign wr.line  = fill_line;

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= ST_IDLE;
            beat        <= '0;
            victim_bits <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (miss_valid) begin
                        state <= ST_REQ;
                    end
                end
                ST_REQ: begin
                    if (rd_rdy) begin
                        state <= ST_RET;
                        beat  <= '0;
                    end
                end
                ST_RET: begin
                    if (ret_valid) begin
                        beat <= beat + 1'b1;  // gaps just stall the count
                    end
                    if (done) begin
                        state <= ST_IDLE;
                    end
                    if (line_done) begin
                        victim_bits[miss_q.req.index] <= !victim_bits[miss_q.req.index];
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == ST_IDLE) && miss_valid) begin
            miss_q     <= miss;
            victim_way <= new_victim;
        end
        if (beat_ok) begin
            line_buf[beat] <= ret_data;
        end
    end

endmodule

// File: hw/icache_top.sv
`timescale 1ns/1ps
`include "icache_macros.svh"

module icache_top (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 valid,
    input  icache_pkg::cpu_req_t req,
    output logic                 addr_ok,
    output logic                 data_ok,
    output logic [31:0]          rdata,
    input  logic                 rd_rdy,
    output logic                 rd_req,
    output logic [2:0]           rd_type,
    output logic [31:0]          rd_addr,
    input  logic                 ret_valid,
    input  logic                 ret_last,
    input  logic [31:0]          ret_data
);
    import icache_pkg::*;

    logic [`ICACHE_INDEX_W-1:0] rd_index;
    tag_entry_t                 tag0;
    tag_entry_t                 tag1;
    line_t                      line0;
    line_t                      line1;
    logic                       busy;
    fill_resp_t                 fill;
    logic                       miss_valid;
    miss_req_t                  miss;
    array_wr_t                  wr;

    icache_lookup_stage lookup0 (
        .clk        (clk),
        .reset      (reset),
        .valid      (valid),
        .req        (req),
        .tag0       (tag0),
        .tag1       (tag1),
        .line0      (line0),
        .line1      (line1),
        .busy       (busy),
        .fill       (fill),
        .addr_ok    (addr_ok),
        .data_ok    (data_ok),
        .rdata      (rdata),
        .rd_index   (rd_index),
        .miss_valid (miss_valid),
        .miss       (miss)
    );

    icache_refill_stage refill0 (
        .clk        (clk),
        .reset      (reset),
        .miss_valid (miss_valid),
        .miss       (miss),
        .rd_rdy     (rd_rdy),
        .ret_valid  (ret_valid),
        .ret_last   (ret_last),
        .ret_data   (ret_data),
        .busy       (busy),
        .fill       (fill),
        .rd_req     (rd_req),
        .rd_type    (rd_type),
        .rd_addr    (rd_addr),
        .wr         (wr)
    );

    // way 0 arrays
    set_ram #(.entry_t(tag_entry_t)) tag_ram0 (
        .clk(clk), .reset(reset), .rd_index(rd_index),
        .wr_en(wr.we0), .wr_index(wr.index), .wr_entry(wr.tag), .rd_entry(tag0)
    );

    set_ram #(.entry_t(line_t)) line_ram0 (
        .clk(clk), .reset(reset), .rd_index(rd_index),
        .wr_en(wr.we0), .wr_index(wr.index), .wr_entry(wr.line), .rd_entry(line0)
    );

    // way 1 arrays
    set_ram #(.entry_t(tag_entry_t)) tag_ram1 (
        .clk(clk), .reset(reset), .rd_index(rd_index),
        .wr_en(wr.we1), .wr_index(wr.index), .wr_entry(wr.tag), .rd_entry(tag1)
    );

    set_ram #(.entry_t(line_t)) line_ram1 (
        .clk(clk), .reset(reset), .rd_index(rd_index),
        .wr_en(wr.we1), .wr_index(wr.index), .wr_entry(wr.line), .rd_entry(line1)
    );

endmodule

// File: testbench/icache_assertions.sv
`timescale 1ns/1ps

module icache_assertions (
    input logic        clk,
    input logic        reset,
    input logic        rd_req,
    input logic        rd_rdy,
    input logic [2:0]  rd_type,
    input logic [31:0] rd_addr
);

    int fails = 0;  // read by the testbench at the end

    // a request stays up until memory takes it
    req_held: assert property (@(posedge clk) disable iff (reset)
        rd_req && !rd_rdy |=> rd_req)
        else begin
            $error("rd_req dropped before rd_rdy");
            fails++;
        end

    addr_stable: assert property (@(posedge clk) disable iff (reset)
        rd_req && !rd_rdy |=> $stable(rd_addr))
        else begin
            $error("rd_addr changed while waiting for rd_rdy");
            fails++;
        end

    type_stable: assert property (@(posedge clk) disable iff (reset)
        rd_req && !rd_rdy |=> $stable(rd_type))
        else begin
            $error("rd_type changed while waiting for rd_rdy");
            fails++;
        end

endmodule

bind icache_refill_stage icache_assertions bus_checks0 (
    .clk     (clk),
    .reset   (reset),
    .rd_req  (rd_req),
    .rd_rdy  (rd_rdy),
    .rd_type (rd_type),
    .rd_addr (rd_addr)
);

// File: testbench/icache_tb.sv
`timescale 1ns/1ps
`include "icache_macros.svh"

module icache_tb;
    import icache_pkg::*;

    localparam int TIMEOUT = 2000;  // cycles per wait

    logic        clk;
    logic        reset;
    logic        valid;
    cpu_req_t    req;
    logic        addr_ok;
    logic        data_ok;
    logic [31:0] rdata;
    logic        rd_rdy = 1'b0;
    logic        rd_req;
    logic [2:0]  rd_type;
    logic [31:0] rd_addr;
    logic        ret_valid = 1'b0;
    logic        ret_last = 1'b0;
    logic [31:0] ret_data = '0;

    logic [31:0] stim_lfsr = 32'hf187;
    logic [31:0] mem_lfsr = 32'hf187;
    logic        mem_active;
    logic [31:0] mem_addr;
    int          mem_beats;
    int          mem_sent;
    logic        hold_rdy;
    logic [31:0] last_addr;
    logic [2:0]  last_type;
    int          bus_reqs;

    logic        model_valid [`ICACHE_SETS][2];
    logic [18:0] model_tag [`ICACHE_SETS][2];
    logic        model_victim [`ICACHE_SETS];

    int errors;
    int test_errors;
    int tests;
    int checks;

    icache_top dut0 (
        .clk(clk), .reset(reset), .valid(valid), .req(req),
        .addr_ok(addr_ok), .data_ok(data_ok), .rdata(rdata),
        .rd_rdy(rd_rdy), .rd_req(rd_req), .rd_type(rd_type), .rd_addr(rd_addr),
        .ret_valid(ret_valid), .ret_last(ret_last), .ret_data(ret_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] stim_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            stim_lfsr = lfsr_step(stim_lfsr);
            v = {v[30:0], stim_lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] mem_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            mem_lfsr = lfsr_step(mem_lfsr);
            v = {v[30:0], mem_lfsr[0]};
        end
        return v;
    endfunction

    // memory with random rd_rdy delay and random gaps between beats
    always @(posedge clk) begin
        if (reset) begin
            rd_rdy     <= 1'b0;
            ret_valid  <= 1'b0;
            ret_last   <= 1'b0;
            mem_active <= 1'b0;
            bus_reqs   <= 0;
        end else begin
            ret_valid <= 1'b0;
            ret_last  <= 1'b0;
            if (!mem_active) begin
                if (rd_req && rd_rdy) begin
                    rd_rdy     <= 1'b0;
                    mem_active <= 1'b1;
                    mem_addr   <= rd_addr;
                    mem_beats  <= (rd_type == 3'(`RD_TYPE_LINE)) ? `ICACHE_WORDS : 1;
                    mem_sent   <= 0;
                    last_addr  <= rd_addr;
                    last_type  <= rd_type;
                    bus_reqs   <= bus_reqs + 1;
                end else if (rd_req && !hold_rdy && (mem_bits(2) == 32'd0)) begin
                    rd_rdy <= 1'b1;
                end
            end else if (mem_bits(2) != 32'd0) begin
                ret_valid <= 1'b1;
                ret_data  <= (mem_addr + 32'(mem_sent * 4)) ^ 32'hc0de0000;
                ret_last  <= (mem_sent == mem_beats - 1);
                mem_sent  <= mem_sent + 1;
                if (mem_sent == mem_beats - 1) begin
                    mem_active <= 1'b0;
                end
            end
        end
    end

    function automatic logic [31:0] make_addr(input logic [1:0] tag_sel,
                                              input logic [1:0] set_sel,
                                              input logic [2:0] word);
        return {17'h0b5c3, tag_sel, set_sel, 6'h15, word, 2'b00};
    endfunction

    function automatic logic [31:0] expected_word(input logic [31:0] addr, input logic unc);
        return (unc ? addr : {addr[31:2], 2'b00}) ^ 32'hc0de0000;
    endfunction

    function automatic cpu_req_t to_req(input logic [31:0] addr, input logic unc);
        return '{tag: addr[31:13], index: addr[12:5], offset: addr[4:0], uncached: unc};
    endfunction

    // returns the expected hit and allocates on a cached miss
    function automatic logic model_access(input logic [31:0] addr, input logic unc);
        logic [18:0] tag;
        logic [7:0]  idx;
        logic        way;
        logic        hit;
        tag = addr[31:13];
        idx = addr[12:5];
        hit = 1'b0;
        for (int w = 0; w < 2; w++) begin
            if (!unc && model_valid[idx][w] && (model_tag[idx][w] == tag)) begin
                hit = 1'b1;
            end
        end
        if (!unc && !hit) begin
            if (!model_valid[idx][0]) begin
                way = 1'b0;
            end else if (!model_valid[idx][1]) begin
                way = 1'b1;
            end else begin
                way = model_victim[idx];
            end
            model_valid[idx][way] = 1'b1;
            model_tag[idx][way]   = tag;
            model_victim[idx]     = !model_victim[idx];
        end
        return hit;
    endfunction

    task automatic finish_run(input logic timed_out);
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if ((errors == 0) && !timed_out) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    endtask

    task automatic give_up(input string what);
        $display("Timeout: no %s within %0d cycles at %0t", what, TIMEOUT, $time);
        errors++;
        finish_run(1'b1);
    endtask

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            $display("Mismatch at %0t: %s is %h, expected %h", $time, name, actual, expected);
            errors++;
            test_errors++;
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("test %0d %s: %s", tests, name, (test_errors == 0) ? "passed" : "FAILED");
        test_errors = 0;
    endtask

    task automatic wait_addr_ok();
        int waited;
        waited = 0;
        @(negedge clk);
        while (!addr_ok) begin
            waited++;
            if (waited > TIMEOUT) begin
                give_up("addr_ok");
            end
            @(negedge clk);
        end
    endtask

    task automatic send_req(input logic [31:0] addr, input logic unc);
        wait_addr_ok();
        @(posedge clk);
        valid <= 1'b1;
        req   <= to_req(addr, unc);
        @(posedge clk);  // accepted here
        valid <= 1'b0;
    endtask

    task automatic wait_data(output logic [31:0] data, output int cycles);
        cycles = 1;
        @(negedge clk);
        while (!data_ok) begin
            cycles++;
            if (cycles > TIMEOUT) begin
                give_up("data_ok");
            end
            @(negedge clk);
        end
        data = rdata;
    endtask

    task automatic access(input logic [31:0] addr, input logic unc);
        logic        exp_hit;
        logic [31:0] data;
        int          cycles;
        int          reqs_before;
        exp_hit     = model_access(addr, unc);
        reqs_before = bus_reqs;
        send_req(addr, unc);
        wait_data(data, cycles);
        check("rdata", data, expected_word(addr, unc));
        check("hit", 32'(cycles == 1), 32'(exp_hit));
        check("bus requests", 32'(bus_reqs - reqs_before), exp_hit ? 32'd0 : 32'd1);
        if (!exp_hit) begin
            check("rd_type", 32'(last_type), unc ? 32'(`RD_TYPE_WORD) : 32'(`RD_TYPE_LINE));
            check("rd_addr", last_addr, unc ? addr : {addr[31:5], 5'b00000});
        end
    endtask

    // two hits on filled lines in consecutive cycles
    task automatic back_to_back(input logic [31:0] a, input logic [31:0] b);
        void'(model_access(a, 1'b0));
        void'(model_access(b, 1'b0));
        wait_addr_ok();
        @(posedge clk);
        valid <= 1'b1;
        req   <= to_req(a, 1'b0);
        @(posedge clk);
        req <= to_req(b, 1'b0);
        @(negedge clk);
        check("data_ok", 32'(data_ok), 32'd1);
        check("rdata", rdata, expected_word(a, 1'b0));
        check("addr_ok", 32'(addr_ok), 32'd1);
        @(posedge clk);
        valid <= 1'b0;
        @(negedge clk);
        check("data_ok", 32'(data_ok), 32'd1);
        check("rdata", rdata, expected_word(b, 1'b0));
    endtask

    initial begin
        logic [31:0] addr;
        logic [31:0] r;
        logic [31:0] data;
        int          cycles;
        reset       = 1'b1;
        valid       = 1'b0;
        req         = '0;
        hold_rdy    = 1'b0;
        errors      = 0;
        test_errors = 0;
        tests       = 0;
        checks      = 0;
        for (int s = 0; s < `ICACHE_SETS; s++) begin
            model_valid[s][0] = 1'b0;
            model_valid[s][1] = 1'b0;
            model_victim[s]   = 1'b0;
        end
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check("addr_ok", 32'(addr_ok), 32'd1);
        check("data_ok", 32'(data_ok), 32'd0);
        check("rd_req", 32'(rd_req), 32'd0);
        end_test("after reset");

        access(make_addr(2'd0, 2'd0, 3'd3), 1'b0);
        end_test("cached miss");

        access(make_addr(2'd0, 2'd0, 3'd5), 1'b0);
        access(make_addr(2'd0, 2'd0, 3'd3), 1'b0);
        access(make_addr(2'd1, 2'd0, 3'd0), 1'b0);  // fills way 1
        back_to_back(make_addr(2'd0, 2'd0, 3'd7), make_addr(2'd1, 2'd0, 3'd2));
        end_test("repeated read of a filled line");

        access(make_addr(2'd2, 2'd1, 3'd4), 1'b1);
        access(make_addr(2'd2, 2'd1, 3'd4), 1'b1);
        access(make_addr(2'd2, 2'd1, 3'd4), 1'b0);  // still a miss
        end_test("uncached read");

        access(make_addr(2'd0, 2'd2, 3'd1), 1'b0);
        access(make_addr(2'd1, 2'd2, 3'd2), 1'b0);
        access(make_addr(2'd2, 2'd2, 3'd3), 1'b0);
        access(make_addr(2'd0, 2'd2, 3'd4), 1'b0);
        access(make_addr(2'd2, 2'd2, 3'd5), 1'b0);
        access(make_addr(2'd1, 2'd2, 3'd6), 1'b0);
        access(make_addr(2'd0, 2'd2, 3'd7), 1'b0);
        access(make_addr(2'd1, 2'd2, 3'd0), 1'b0);
        end_test("third tag in a full set");

        hold_rdy = 1'b1;
        addr     = make_addr(2'd3, 2'd3, 3'd6);
        void'(model_access(addr, 1'b1));
        send_req(addr, 1'b1);
        for (int i = 0; i < 20; i++) begin
            @(negedge clk);
            check("addr_ok", 32'(addr_ok), 32'd0);
            if (i > 0) begin
                check("rd_req", 32'(rd_req), 32'd1);
            end
        end
        hold_rdy = 1'b0;
        wait_data(data, cycles);
        check("rdata", data, expected_word(addr, 1'b1));
        for (int n = 0; n < 300; n++) begin
            r = stim_bits(10);
            access(make_addr(r[1:0], r[3:2], r[6:4]), r[9:7] == 3'd0);
        end
        end_test("rd_rdy held low and random run");

        check("assertion failures", 32'(dut0.refill0.bus_checks0.fails), 32'd0);
        finish_run(1'b0);
    end

endmodule

// File: list.f
+incdir+hw
hw/icache_pkg.sv
hw/set_ram.sv
hw/icache_lookup_stage.sv
hw/icache_refill_stage.sv
hw/icache_top.sv
testbench/icache_assertions.sv
testbench/icache_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = icache_tb
FILELIST  = list.f
OBJ_DIR   = obj_dir
PASS_MSG  = No errors

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory"
	@echo "make help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
